// ==== logic/rvCorePkg.sv ====
package rvCorePkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSll, aluSrl, aluSra, aluSlt, aluSltu,
    aluPassB  // lui
  } aluOpT;

  typedef enum logic [2:0] {
    brEq, brNe, brLt, brGe, brLtu, brGeu, brNone
  } branchOpT;

  typedef enum logic [1:0] {wbAlu, wbLoad, wbLink} wbSelT;

  typedef enum logic [1:0] {pcPlus4, pcBranch, pcJal, pcJalr} pcSelT;

  typedef enum logic [2:0] {
    stFetchAddr, stFetchData, stExecute, stMemAddr, stMemData, stWriteBack, stHalt
  } coreStateT;

  typedef enum logic [1:0] {
    respOkay   = 2'b00,
    respSlvErr = 2'b10
  } axiRespT;

endpackage

// ==== logic/execBus.sv ====
`timescale 1ns/1ps

interface execBus;
  logic [rvCorePkg::xlen-1:0] pc;
  logic [rvCorePkg::xlen-1:0] rs1Data;
  logic [rvCorePkg::xlen-1:0] rs2Data;
  logic [rvCorePkg::xlen-1:0] imm;
  rvCorePkg::aluOpT aluOp;
  logic srcAPc;   // operand a from pc
  logic srcBImm;  // operand b from imm
  rvCorePkg::branchOpT branchOp;
  rvCorePkg::wbSelT wbSel;
  rvCorePkg::pcSelT pcSel;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic halt;

  modport producer (
    output imm, aluOp, srcAPc, srcBImm, branchOp, wbSel, pcSel,
    output regWrite, memRead, memWrite, halt
  );

  modport consumer (
    input pc, rs1Data, rs2Data, imm, aluOp, srcAPc, srcBImm, branchOp, wbSel, pcSel,
    input regWrite, memRead, memWrite, halt
  );
endinterface

// ==== logic/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit (
  input  logic [rvCorePkg::xlen-1:0] instr,
  output logic [4:0]                 rs1,
  output logic [4:0]                 rs2,
  output logic [4:0]                 rd,
  execBus.producer                   ex
);
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [rvCorePkg::xlen-1:0] immI;
  logic [rvCorePkg::xlen-1:0] immS;
  logic [rvCorePkg::xlen-1:0] immB;
  logic [rvCorePkg::xlen-1:0] immU;
  logic [rvCorePkg::xlen-1:0] immJ;

  // shared by op-imm and op-reg, alt picks sub / sra
  function automatic rvCorePkg::aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
      3'b001:  return rvCorePkg::aluSll;
      3'b010:  return rvCorePkg::aluSlt;
      3'b011:  return rvCorePkg::aluSltu;
      3'b100:  return rvCorePkg::aluXor;
      3'b101:  return alt ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
      3'b110:  return rvCorePkg::aluOr;
      default: return rvCorePkg::aluAnd;
    endcase
  endfunction

  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ex.imm      = immI;
    ex.aluOp    = rvCorePkg::aluAdd;
    ex.srcAPc   = 1'b0;
    ex.srcBImm  = 1'b1;
    ex.branchOp = rvCorePkg::brNone;
    ex.wbSel    = rvCorePkg::wbAlu;
    ex.pcSel    = rvCorePkg::pcPlus4;
    ex.regWrite = 1'b0;
    ex.memRead  = 1'b0;
    ex.memWrite = 1'b0;
    ex.halt     = 1'b0;
    case (rvCorePkg::opcodeT'(instr[6:0]))
      rvCorePkg::opLui: begin
        ex.imm      = immU;
        ex.aluOp    = rvCorePkg::aluPassB;
        ex.regWrite = 1'b1;
      end
      rvCorePkg::opAuipc: begin
        ex.imm      = immU;
        ex.srcAPc   = 1'b1;
        ex.regWrite = 1'b1;
      end
      rvCorePkg::opJal: begin
        ex.imm      = immJ;
        ex.pcSel    = rvCorePkg::pcJal;
        ex.wbSel    = rvCorePkg::wbLink;
        ex.regWrite = 1'b1;
      end
      rvCorePkg::opJalr: begin
        ex.pcSel    = rvCorePkg::pcJalr;
        ex.wbSel    = rvCorePkg::wbLink;
        ex.regWrite = 1'b1;
        ex.halt     = funct3 != 3'b000;
      end
      rvCorePkg::opBranch: begin
        ex.imm     = immB;
        ex.srcBImm = 1'b0;
        ex.pcSel   = rvCorePkg::pcBranch;
        case (funct3)
          3'b000:  ex.branchOp = rvCorePkg::brEq;
          3'b001:  ex.branchOp = rvCorePkg::brNe;
          3'b100:  ex.branchOp = rvCorePkg::brLt;
          3'b101:  ex.branchOp = rvCorePkg::brGe;
          3'b110:  ex.branchOp = rvCorePkg::brLtu;
          3'b111:  ex.branchOp = rvCorePkg::brGeu;
          default: ex.halt     = 1'b1;
        endcase
      end
      rvCorePkg::opLoad: begin
        ex.memRead  = 1'b1;
        ex.wbSel    = rvCorePkg::wbLoad;
        ex.regWrite = 1'b1;
        ex.halt     = funct3 != 3'b010;  // word only
      end
      rvCorePkg::opStore: begin
        ex.imm      = immS;
        ex.memWrite = 1'b1;
        ex.halt     = funct3 != 3'b010;
      end
      rvCorePkg::opImm: begin
        ex.aluOp    = aluFromFunct(funct3, funct3 == 3'b101 && funct7[5]);
        ex.regWrite = 1'b1;
        ex.halt     = (funct3 == 3'b001 && funct7 != 7'h00) ||
                      (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20);
      end
      rvCorePkg::opReg: begin
        ex.srcBImm  = 1'b0;
        ex.aluOp    = aluFromFunct(funct3, funct7[5]);
        ex.regWrite = 1'b1;
        ex.halt     = funct7 != 7'h00 &&
                      !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: ex.halt = 1'b1;  // ebreak, and anything unsupported
    endcase
    // halting instruction has no side effects
    if (ex.halt) begin
      ex.regWrite = 1'b0;
      ex.memRead  = 1'b0;
      ex.memWrite = 1'b0;
      ex.pcSel    = rvCorePkg::pcPlus4;
    end
  end
endmodule

// ==== logic/regArray.sv ====
`timescale 1ns/1ps

module regArray (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [4:0]                 rs1,
  input  logic [4:0]                 rs2,
  input  logic [4:0]                 rd,
  input  logic [rvCorePkg::xlen-1:0] wd,
  input  logic                       we,
  output logic [rvCorePkg::xlen-1:0] rsa,
  output logic [rvCorePkg::xlen-1:0] rsb
);
  logic [rvCorePkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin  // x0 stays zero
      regs[rd] <= wd;
    end
  end

  assign rsa = regs[rs1];
  assign rsb = regs[rs2];
endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
  execBus.consumer                   ex,
  output logic [rvCorePkg::xlen-1:0] aluResult
);
  logic [rvCorePkg::xlen-1:0] srcA;
  logic [rvCorePkg::xlen-1:0] srcB;
  logic [4:0] shamt;

  assign srcA  = ex.srcAPc ? ex.pc : ex.rs1Data;
  assign srcB  = ex.srcBImm ? ex.imm : ex.rs2Data;
  assign shamt = srcB[4:0];

  always_comb begin
    case (ex.aluOp)
      rvCorePkg::aluAdd:   aluResult = srcA + srcB;
      rvCorePkg::aluSub:   aluResult = srcA - srcB;
      rvCorePkg::aluAnd:   aluResult = srcA & srcB;
      rvCorePkg::aluOr:    aluResult = srcA | srcB;
      rvCorePkg::aluXor:   aluResult = srcA ^ srcB;
      rvCorePkg::aluSll:   aluResult = srcA << shamt;
      rvCorePkg::aluSrl:   aluResult = srcA >> shamt;
      rvCorePkg::aluSra:   aluResult = $signed(srcA) >>> shamt;  // sign fill
      rvCorePkg::aluSlt: begin
        aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
      end
      rvCorePkg::aluSltu:  aluResult = {31'b0, srcA < srcB};
      rvCorePkg::aluPassB: aluResult = srcB;
      default:             aluResult = srcA + srcB;
    endcase
  end
endmodule

// ==== logic/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit (
  execBus.consumer ex,
  output logic     taken
);
  logic eq;
  logic ltSigned;
  logic ltUnsigned;

  assign eq         = ex.rs1Data == ex.rs2Data;
  assign ltSigned   = $signed(ex.rs1Data) < $signed(ex.rs2Data);
  assign ltUnsigned = ex.rs1Data < ex.rs2Data;

  always_comb begin
    case (ex.branchOp)
      rvCorePkg::brEq:  taken = eq;
      rvCorePkg::brNe:  taken = !eq;
      rvCorePkg::brLt:  taken = ltSigned;
      rvCorePkg::brGe:  taken = !ltSigned;
      rvCorePkg::brLtu: taken = ltUnsigned;
      rvCorePkg::brGeu: taken = !ltUnsigned;
      default:          taken = 1'b0;  // brNone
    endcase
  end
endmodule

// ==== logic/commitUnit.sv ====
`timescale 1ns/1ps

module commitUnit (
  execBus.consumer                   ex,
  input  logic [rvCorePkg::xlen-1:0] aluResult,
  input  logic                       taken,
  input  logic [rvCorePkg::xlen-1:0] loadData,
  output logic [rvCorePkg::xlen-1:0] wbData,
  output logic [rvCorePkg::xlen-1:0] nextPc
);
  logic [rvCorePkg::xlen-1:0] pcPlus4;
  logic [rvCorePkg::xlen-1:0] pcTarget;

  assign pcPlus4  = ex.pc + 32'd4;
  assign pcTarget = ex.pc + ex.imm;  // branch and jal

  always_comb begin
    case (ex.wbSel)
      rvCorePkg::wbLoad: wbData = loadData;
      rvCorePkg::wbLink: wbData = pcPlus4;
      default:           wbData = aluResult;
    endcase
  end

  always_comb begin
    case (ex.pcSel)
      rvCorePkg::pcBranch: nextPc = taken ? pcTarget : pcPlus4;
      rvCorePkg::pcJal:    nextPc = pcTarget;
      rvCorePkg::pcJalr:   nextPc = {aluResult[rvCorePkg::xlen-1:1], 1'b0};
      default:             nextPc = pcPlus4;
    endcase
  end
endmodule

// ==== logic/busMaster.sv ====
`timescale 1ns/1ps

module busMaster (
  input  logic                       clk,
  input  logic                       rst,
  output logic [rvCorePkg::xlen-1:0] araddr,
  output logic                       arvalid,
  input  logic                       arready,
  input  logic [rvCorePkg::xlen-1:0] rdata,
  input  logic [1:0]                 rresp,
  input  logic                       rvalid,
  output logic                       rready,
  output logic [rvCorePkg::xlen-1:0] awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output logic [rvCorePkg::xlen-1:0] wdata,
  output logic [3:0]                 wstrb,
  output logic                       wvalid,
  input  logic                       wready,
  input  logic [1:0]                 bresp,
  input  logic                       bvalid,
  output logic                       bready,
  execBus.consumer                   ex,
  input  logic [rvCorePkg::xlen-1:0] aluResult,
  input  logic [rvCorePkg::xlen-1:0] nextPc,
  input  logic [rvCorePkg::xlen-1:0] wbData,
  input  logic [4:0]                 rd,
  output logic [rvCorePkg::xlen-1:0] instr,
  output logic [rvCorePkg::xlen-1:0] loadData,
  output logic [rvCorePkg::xlen-1:0] pc,
  output logic                       regWe,
  output logic                       retireValid,
  output logic [rvCorePkg::xlen-1:0] retirePc,
  output logic [4:0]                 retireRd,
  output logic [rvCorePkg::xlen-1:0] retireData,
  output logic                       halted,
  output logic                       busError
);
  rvCorePkg::coreStateT state;
  rvCorePkg::coreStateT stateNext;
  logic awDone;
  logic wDone;
  logic arHs;
  logic rHs;
  logic awHs;
  logic wHs;
  logic bHs;
  logic respBad;

  assign arHs = arvalid && arready;
  assign rHs  = rvalid && rready;
  assign awHs = awvalid && awready;
  assign wHs  = wvalid && wready;
  assign bHs  = bvalid && bready;
  assign respBad = (rHs && rresp != rvCorePkg::respOkay) ||
                   (bHs && bresp != rvCorePkg::respOkay);

  // fetch uses pc, loads and stores use the alu address
  assign arvalid = state == rvCorePkg::stFetchAddr ||
                   (state == rvCorePkg::stMemAddr && ex.memRead);
  assign araddr  = (state == rvCorePkg::stMemAddr) ? aluResult : pc;
  assign rready  = state == rvCorePkg::stFetchData ||
                   (state == rvCorePkg::stMemData && ex.memRead);
  assign awvalid = state == rvCorePkg::stMemAddr && ex.memWrite && !awDone;
  assign awaddr  = aluResult;
  assign wvalid  = state == rvCorePkg::stMemAddr && ex.memWrite && !wDone;
  assign wdata   = ex.rs2Data;
  assign wstrb   = 4'hf;
  assign bready  = state == rvCorePkg::stMemData && ex.memWrite;

  assign regWe       = state == rvCorePkg::stWriteBack && ex.regWrite;
  assign retireValid = state == rvCorePkg::stWriteBack;
  assign retirePc    = pc;
  assign retireRd    = ex.regWrite ? rd : 5'd0;
  assign retireData  = ex.regWrite ? wbData : '0;
  assign halted      = state == rvCorePkg::stHalt;

  always_comb begin
    stateNext = state;
    case (state)
      rvCorePkg::stFetchAddr: if (arHs) stateNext = rvCorePkg::stFetchData;
      rvCorePkg::stFetchData: begin
        if (rHs) stateNext = respBad ? rvCorePkg::stHalt : rvCorePkg::stExecute;
      end
      rvCorePkg::stExecute: begin
        if (ex.memRead || ex.memWrite) stateNext = rvCorePkg::stMemAddr;
        else stateNext = rvCorePkg::stWriteBack;
      end
      rvCorePkg::stMemAddr: begin
        if (ex.memRead && arHs) stateNext = rvCorePkg::stMemData;
        if (ex.memWrite && (awDone || awHs) && (wDone || wHs)) stateNext = rvCorePkg::stMemData;
      end
      rvCorePkg::stMemData: begin
        if (rHs || bHs) stateNext = respBad ? rvCorePkg::stHalt : rvCorePkg::stWriteBack;
      end
      rvCorePkg::stWriteBack: stateNext = ex.halt ? rvCorePkg::stHalt : rvCorePkg::stFetchAddr;
      default: stateNext = rvCorePkg::stHalt;  // stays stopped
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= rvCorePkg::stFetchAddr;
      pc       <= rvCorePkg::resetPc;
      awDone   <= 1'b0;
      wDone    <= 1'b0;
      busError <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == rvCorePkg::stWriteBack) pc <= nextPc;
      // aw and w may complete in either order
      if (stateNext != rvCorePkg::stMemAddr) begin
        awDone <= 1'b0;
        wDone  <= 1'b0;
      end else begin
        if (awHs) awDone <= 1'b1;
        if (wHs) wDone <= 1'b1;
      end
      if (respBad) busError <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rHs && state == rvCorePkg::stFetchData) instr <= rdata;
    if (rHs && state == rvCorePkg::stMemData) loadData <= rdata;
  end
endmodule

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
  input  logic                       clk,
  input  logic                       rst,
  output logic [rvCorePkg::xlen-1:0] araddr,
  output logic                       arvalid,
  input  logic                       arready,
  input  logic [rvCorePkg::xlen-1:0] rdata,
  input  logic [1:0]                 rresp,
  input  logic                       rvalid,
  output logic                       rready,
  output logic [rvCorePkg::xlen-1:0] awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output logic [rvCorePkg::xlen-1:0] wdata,
  output logic [3:0]                 wstrb,
  output logic                       wvalid,
  input  logic                       wready,
  input  logic [1:0]                 bresp,
  input  logic                       bvalid,
  output logic                       bready,
  output logic                       retireValid,
  output logic [rvCorePkg::xlen-1:0] retirePc,
  output logic [4:0]                 retireRd,
  output logic [rvCorePkg::xlen-1:0] retireData,
  output logic                       halted,
  output logic                       busError
);
  execBus bus ();

  logic [rvCorePkg::xlen-1:0] instr;
  logic [rvCorePkg::xlen-1:0] loadData;
  logic [rvCorePkg::xlen-1:0] pc;
  logic [rvCorePkg::xlen-1:0] aluResult;
  logic [rvCorePkg::xlen-1:0] nextPc;
  logic [rvCorePkg::xlen-1:0] wbData;
  logic [rvCorePkg::xlen-1:0] rsa;
  logic [rvCorePkg::xlen-1:0] rsb;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  logic regWe;
  logic taken;

  assign bus.pc      = pc;
  assign bus.rs1Data = rsa;
  assign bus.rs2Data = rsb;

  busMaster ctrl (
    .clk(clk), .rst(rst),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .ex(bus.consumer),
    .aluResult(aluResult), .nextPc(nextPc), .wbData(wbData), .rd(rd),
    .instr(instr), .loadData(loadData), .pc(pc), .regWe(regWe),
    .retireValid(retireValid), .retirePc(retirePc),
    .retireRd(retireRd), .retireData(retireData),
    .halted(halted), .busError(busError)
  );

  decodeUnit dec (.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .ex(bus.producer));

  regArray regs (
    .clk(clk), .rst(rst),
    .rs1(rs1), .rs2(rs2), .rd(rd),
    .wd(wbData), .we(regWe),
    .rsa(rsa), .rsb(rsb)
  );

  aluUnit alu (.ex(bus.consumer), .aluResult(aluResult));

  branchUnit bru (.ex(bus.consumer), .taken(taken));

  commitUnit commit (
    .ex(bus.consumer),
    .aluResult(aluResult), .taken(taken), .loadData(loadData),
    .wbData(wbData), .nextPc(nextPc)
  );
endmodule

// ==== testbench/axiMemory.sv ====
`timescale 1ns/1ps

module axiMemory (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready
);
  logic [31:0] words [1024];
  logic        errArm;   // set by the testbench
  logic [31:0] errAddr;
  logic [31:0] rAddr;
  logic [31:0] wAddr;
  logic [31:0] wData;
  logic [3:0]  wStrb;
  logic rstSeen;
  logic rPend, awGot, wGot;
  logic arHs, rHs, awHs, wHs, bHs, arSeen, awSeen, wSeen;
  int arWait, rWait, awWait, wWait, bWait;

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = 2'b00;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = 2'b00;
    errArm  = 1'b0;
    errAddr = '0;
  end

  always @(posedge clk) begin
    // sample handshakes at the edge, respond a little later
    rstSeen = rst;
    arHs   = arvalid && arready;
    rHs    = rvalid && rready;
    awHs   = awvalid && awready;
    wHs    = wvalid && wready;
    bHs    = bvalid && bready;
    arSeen = arvalid;
    awSeen = awvalid;
    wSeen  = wvalid;
    if (arHs) rAddr = araddr;
    if (awHs) wAddr = awaddr;
    if (wHs) begin
      wData = wdata;
      wStrb = wstrb;
    end
    #1;
    if (!rstSeen) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      rPend   = 1'b0;
      awGot   = 1'b0;
      wGot    = 1'b0;
      arWait  = 0;
      rWait   = 0;
      awWait  = 0;
      wWait   = 0;
      bWait   = 0;
    end else begin
      if (rHs) begin
        rvalid = 1'b0;
        rPend  = 1'b0;
        arWait = $urandom % 4;
      end else if (arHs) begin
        arready = 1'b0;
        rPend   = 1'b1;
        rWait   = $urandom % 4;
      end else if (rPend && !rvalid) begin
        if (rWait == 0) begin
          rvalid = 1'b1;
          rdata  = words[rAddr[11:2]];
          rresp  = (errArm && rAddr == errAddr) ? 2'b10 : 2'b00;  // injected slave error
        end else rWait--;
      end else if (arSeen && !arready && !rPend) begin
        if (arWait == 0) arready = 1'b1;
        else arWait--;
      end

      if (bHs) begin
        bvalid = 1'b0;
        awGot  = 1'b0;
        wGot   = 1'b0;
        awWait = $urandom % 4;
        wWait  = $urandom % 4;
        bWait  = $urandom % 4;
      end else begin
        if (awHs) begin
          awready = 1'b0;
          awGot   = 1'b1;
        end else if (awSeen && !awready && !awGot) begin
          if (awWait == 0) awready = 1'b1;
          else awWait--;
        end
        if (wHs) begin
          wready = 1'b0;
          wGot   = 1'b1;
        end else if (wSeen && !wready && !wGot) begin
          if (wWait == 0) wready = 1'b1;
          else wWait--;
        end
        if (awGot && wGot && !bvalid) begin
          if (bWait == 0) begin
            for (int lane = 0; lane < 4; lane++) begin
              if (wStrb[lane]) begin
                words[wAddr[11:2]][8*lane +: 8] = wData[8*lane +: 8];  // byte lanes per strobe
              end
            end
            bvalid = 1'b1;
            bresp  = 2'b00;
          end else bWait--;
        end
      end
    end
  end
endmodule

// ==== testbench/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;
  localparam int progWords = 160;
  localparam int dataBase  = 384;  // word index of byte 0x600

  logic clk;
  logic rst;
  logic [31:0] araddr, rdata, awaddr, wdata, retirePc, retireData;
  logic [1:0] rresp, bresp;
  logic [3:0] wstrb;
  logic [4:0] retireRd;
  logic arvalid, arready, rvalid, rready, awvalid, awready;
  logic wvalid, wready, bvalid, bready, retireValid, halted, busError;

  logic [31:0] model [1024];
  logic [rvCorePkg::xlen-1:0] expPc [$];
  logic [4:0] expRd [$];
  logic [rvCorePkg::xlen-1:0] expData [$];
  int errors;
  int checks;
  int numInstr;

  rvCore UUT (.*);

  axiMemory mem (.*);

  always #20 clk = ~clk;

  task automatic checkPc(input string name, input logic [rvCorePkg::xlen-1:0] exp,
                         input logic [rvCorePkg::xlen-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s retirePc: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkRd(input string name, input logic [4:0] exp, input logic [4:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s retireRd: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic checkData(input string name, input logic [rvCorePkg::xlen-1:0] exp,
                           input logic [rvCorePkg::xlen-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s data: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s flag: expected %b actual %b", name, exp, act);
    end
  endtask

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};  // base x0
  endfunction

  function automatic logic [31:0] aluCalc(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic fillMemory();
    for (int i = 0; i < 1024; i++) begin
      mem.words[i] = (i * 32'h9e37_79b1) ^ {i[15:0], ~i[15:0]};
    end
  endtask

  task automatic genProgram();
    int idx;
    int kind;
    logic [2:0] f3;
    logic [4:0] ra, rb, rd;
    logic [11:0] off;
    logic [2:0] brF3 [6];
    brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    idx = 0;
    while (idx < progWords - 6) begin
      kind = $urandom % 10;
      f3 = $urandom;
      ra = $urandom;
      rb = $urandom;
      rd = $urandom;
      case (kind)
        0, 1, 2: begin
          if (f3 == 3'd1) off = {7'h00, 5'($urandom)};
          else if (f3 == 3'd5) off = {($urandom % 2) ? 7'h20 : 7'h00, 5'($urandom)};
          else off = $urandom;
          mem.words[idx] = encI(off, ra, f3, rd, 7'h13);
        end
        3, 4: begin
          mem.words[idx] = {((f3 == 0 || f3 == 5) && $urandom % 2) ? 7'h20 : 7'h00,
                            rb, ra, f3, rd, 7'h33};
        end
        5: mem.words[idx] = {20'($urandom), rd, ($urandom % 2) ? 7'h37 : 7'h17};
        6: begin
          if ($urandom % 4 == 0) rb = ra;  // makes equal operands likely
          mem.words[idx] = encB(brF3[$urandom % 6], ra, rb, ($urandom % 2) ? 13'd8 : 13'd12);
        end
        7: mem.words[idx] = encJ(rd, ($urandom % 2) ? 21'd8 : 21'd12);
        8: begin
          // odd absolute target from x0, jalr clears bit 0 and skips one word
          mem.words[idx] = encI(12'(idx * 4 + 9), 5'd0, 3'd0, rd, 7'h67);
        end
        default: begin
          off = 12'h600 + 12'(($urandom % 128) * 4);
          mem.words[idx] = encS(off, rb);
          idx++;
          mem.words[idx] = encI(off, 5'd0, 3'b010, rd, 7'h03);
        end
      endcase
      idx++;
    end
    for (int i = idx; i < progWords; i++) begin
      mem.words[i] = 32'h0010_0073;  // ebreak padding
    end
    numInstr = progWords;
  endtask

  task automatic runModel();
    logic [31:0] x [32];
    logic [31:0] pc, ins, a, b, res, nxt, addr, immI;
    logic [4:0] rd;
    logic [2:0] f3;
    logic wr;
    logic done;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 1024; i++) model[i] = mem.words[i];
    pc = rvCorePkg::resetPc;
    done = 1'b0;
    while (!done) begin
      ins  = model[pc[11:2]];
      rd   = ins[11:7];
      f3   = ins[14:12];
      a    = x[ins[19:15]];
      b    = x[ins[24:20]];
      immI = {{20{ins[31]}}, ins[31:20]};
      nxt  = pc + 4;
      wr   = 1'b1;
      res  = '0;
      case (ins[6:0])
        7'h37: res = {ins[31:12], 12'b0};
        7'h17: res = pc + {ins[31:12], 12'b0};
        7'h6f: begin
          res = pc + 4;
          nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h67: begin
          res = pc + 4;
          nxt = (a + immI) & ~32'd1;
        end
        7'h63: begin
          wr = 1'b0;
          if (branchTaken(f3, a, b)) begin
            nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        7'h03: begin
          addr = a + immI;
          res  = model[addr[11:2]];
        end
        7'h23: begin
          wr   = 1'b0;
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          model[addr[11:2]] = b;
        end
        7'h13: res = aluCalc(f3, ins[30] && f3 == 3'd5, a, immI);
        7'h33: res = aluCalc(f3, ins[30], a, b);
        default: begin
          wr   = 1'b0;
          done = 1'b1;
        end
      endcase
      expPc.push_back(pc);
      expRd.push_back(wr ? rd : 5'd0);
      expData.push_back(wr ? res : 32'd0);
      if (wr && rd != 5'd0) x[rd] = res;
      pc = nxt;
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1 rst = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b1;
  endtask

  task automatic runProgram(input string name, input logic expectErr);
    int limit;
    int cycle;
    int startErr;
    limit = 12 * numInstr * 8;
    cycle = 0;
    startErr = errors;
    applyReset();
    while (!halted) begin
      @(negedge clk);
      cycle++;
      if (cycle > limit) begin
        $display("timeout: %s did not halt within %0d cycles", name, limit);
        $display("CHECKS FAILED");
        $finish;
      end else if (retireValid) begin
        if (expPc.size() == 0) begin
          errors++;
          $display("%s: instruction retired when none was expected", name);
        end else begin
          checkPc(name, expPc.pop_front(), retirePc);
          checkRd(name, expRd.pop_front(), retireRd);
          checkData(name, expData.pop_front(), retireData);
        end
      end
    end
    if (expPc.size() != 0) begin
      errors++;
      $display("%s: core halted with %0d instructions not retired", name, expPc.size());
    end
    repeat (10) begin
      @(negedge clk);
      checkFlag(name, 1'b0, retireValid);  // nothing retires once stopped
      checkFlag(name, 1'b1, halted);
    end
    checkFlag(name, expectErr, busError);
    $display("test %s: %s, %0d errors", name, (errors == startErr) ? "ok" : "bad",
             errors - startErr);
  endtask

  initial begin
    int startErr;
    clk = 1'b0;
    rst = 1'b0;
    errors = 0;
    checks = 0;
    void'($urandom(48833));

    fillMemory();
    genProgram();
    runModel();
    runProgram("randomProgram", 1'b0);

    startErr = errors;
    for (int i = dataBase; i < 512; i++) begin
      checkData("dataMemory", model[i], mem.words[i]);
    end
    $display("test dataMemory: %s, %0d errors", (errors == startErr) ? "ok" : "bad",
             errors - startErr);

    // two addi retire, then the third fetch gets a slave error
    fillMemory();
    mem.words[0] = encI(12'd5, 5'd0, 3'd0, 5'd1, 7'h13);
    mem.words[1] = encI(12'd7, 5'd1, 3'd0, 5'd2, 7'h13);
    mem.words[2] = encI(12'd1, 5'd2, 3'd0, 5'd3, 7'h13);
    mem.words[3] = 32'h0010_0073;
    mem.errAddr = 32'd8;
    mem.errArm  = 1'b1;
    expPc.push_back(32'd0);
    expRd.push_back(5'd1);
    expData.push_back(32'd5);
    expPc.push_back(32'd4);
    expRd.push_back(5'd2);
    expData.push_back(32'd12);
    numInstr = 4;
    runProgram("fetchError", 1'b1);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end
endmodule

// ==== rvCore.f ====
logic/rvCorePkg.sv
logic/execBus.sv
logic/decodeUnit.sv
logic/regArray.sv
logic/aluUnit.sv
logic/branchUnit.sv
logic/commitUnit.sv
logic/busMaster.sv
logic/rvCore.sv
testbench/axiMemory.sv
testbench/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvCore

sources:
  - logic/rvCorePkg.sv
  - logic/execBus.sv
  - logic/decodeUnit.sv
  - logic/regArray.sv
  - logic/aluUnit.sv
  - logic/branchUnit.sv
  - logic/commitUnit.sv
  - logic/busMaster.sv
  - logic/rvCore.sv
  - target: simulation
    files:
      - testbench/axiMemory.sv
      - testbench/rvCoreTb.sv
